// ==== common/sram_fifo_pkg.sv ====
// widths, word types and the burst pacing enum shared by the sram queue design
`default_nettype none

package sram_fifo_pkg;

    ////////////////////////////////////////
    // queue and word geometry
    ////////////////////////////////////////

    // four queues, each owning a quarter of the sram
    localparam int NUM_QUEUES  = 4;
    localparam int QUEUE_ID_W  = 2;

    // 32 data bits plus end of packet
    localparam int DATA_W      = 33;

    // default sram word address width, top level overrides
    localparam int ADDR_W      = 8;

    // slots held back before a queue reports full
    localparam int FULL_MARGIN = 5;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic [QUEUE_ID_W-1:0] queue_id_t;
    typedef logic [DATA_W-1:0]     payload_t;

    // stored word is {valid, queue id, payload}
    typedef logic [DATA_W+QUEUE_ID_W:0] mem_word_t;

    // one bit per queue
    typedef logic [NUM_QUEUES-1:0] queue_flags_t;

    // one cycle pause after every accepted access
    typedef enum logic
    {
        burst_off,
        burst_halfway
    } burst_state_t;

endpackage

`default_nettype wire

// ==== queue_mgr/queue_table.sv ====
// per-queue head and tail pointers, occupancy counters and empty/full flags
`timescale 1ns/100ps
`default_nettype none

module queue_table
#(
    parameter int addr_w = sram_fifo_pkg::ADDR_W
)
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        write_accept,
    input  wire sram_fifo_pkg::queue_id_t write_accept_id,
    input  wire                        read_accept,
    input  wire sram_fifo_pkg::queue_id_t read_accept_id,
    input  wire sram_fifo_pkg::queue_id_t write_queue_id,
    input  wire sram_fifo_pkg::queue_id_t read_queue_id,
    output logic [addr_w-1:0]          tail_addr,
    output logic [addr_w-1:0]          head_addr,
    output sram_fifo_pkg::queue_flags_t write_full,
    output sram_fifo_pkg::queue_flags_t read_empty
);

    import sram_fifo_pkg::*;

    // low address bits wrap inside a region
    localparam int off_w = addr_w - QUEUE_ID_W;
    localparam int cnt_w = off_w + 1;
    localparam int depth = 1 << off_w;
    localparam logic [cnt_w-1:0] full_level = cnt_w'(depth - FULL_MARGIN);

    logic [addr_w-1:0] head [NUM_QUEUES];
    logic [addr_w-1:0] tail [NUM_QUEUES];
    logic [cnt_w-1:0]  occ  [NUM_QUEUES];

    queue_flags_t wr_hit;
    queue_flags_t rd_hit;

    // decode which queue each side touches this cycle
    always_comb
    begin
        wr_hit = '0;
        rd_hit = '0;
        wr_hit[write_accept_id] = write_accept;
        rd_hit[read_accept_id]  = read_accept;
    end

    ////////////////////////////////////////
    // pointer and occupancy registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            if (reset)
            begin
                // every pointer starts at the base of its region
                head[q] <= {queue_id_t'(q), {off_w{1'b0}}};
                tail[q] <= {queue_id_t'(q), {off_w{1'b0}}};
                occ[q]  <= '0;
            end
            else
            begin
                if (wr_hit[q])
                    tail[q] <= {queue_id_t'(q), tail[q][off_w-1:0] + 1'b1};
                if (rd_hit[q])
                    head[q] <= {queue_id_t'(q), head[q][off_w-1:0] + 1'b1};
                // simultaneous write and read cancel out
                case ({wr_hit[q], rd_hit[q]})
                    2'b10:   occ[q] <= occ[q] + 1'b1;
                    2'b01:   occ[q] <= occ[q] - 1'b1;
                    default: occ[q] <= occ[q];
                endcase
            end
        end
    end

    assign tail_addr = tail[write_queue_id];
    assign head_addr = head[read_queue_id];

    always_comb
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            read_empty[q] = (occ[q] == '0);
            write_full[q] = (occ[q] >= full_level);
        end
    end

    // issuers must respect the flags
    for (genvar g = 0; g < NUM_QUEUES; g++)
    begin : g_occ_check
        assert property (@(posedge clk) disable iff (reset) rd_hit[g] |-> occ[g] != '0)
            else $error("queue %0d read while empty", g);
        assert property (@(posedge clk) disable iff (reset) occ[g] <= cnt_w'(depth))
            else $error("queue %0d occupancy above depth", g);
    end

endmodule

`default_nettype wire

// ==== queue_mgr/write_issue.sv ====
// write side pacing fsm and sram write port register
`timescale 1ns/100ps
`default_nettype none

module write_issue
#(
    parameter int addr_w = sram_fifo_pkg::ADDR_W
)
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           write_valid,
    input  wire sram_fifo_pkg::queue_id_t write_queue_id,
    input  wire sram_fifo_pkg::payload_t  write_data,
    input  wire sram_fifo_pkg::queue_flags_t write_full,
    input  wire [addr_w-1:0]              tail_addr,
    output logic                          write_accept,
    output sram_fifo_pkg::queue_id_t      write_accept_id,
    output logic                          write_busy,
    output logic                          mem_wr_en,
    output logic [addr_w-1:0]             mem_wr_addr,
    output sram_fifo_pkg::mem_word_t      mem_wr_data
);

    import sram_fifo_pkg::*;

    burst_state_t state;
    burst_state_t state_next;

    // idle for one cycle after each acceptance
    assign write_busy      = (state == burst_halfway);
    assign write_accept    = write_valid && !write_busy && !write_full[write_queue_id];
    assign write_accept_id = write_queue_id;

    always_comb
    begin
        case (state)
            burst_off:     state_next = write_accept ? burst_halfway : burst_off;
            burst_halfway: state_next = burst_off;
            default:       state_next = burst_off;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= burst_off;
            mem_wr_en <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            mem_wr_en <= write_accept;
        end
    end

    // old tail and packed word, valid bit set
    always_ff @(posedge clk)
    begin
        mem_wr_addr <= tail_addr;
        mem_wr_data <= {1'b1, write_queue_id, write_data};
    end

    assert property (@(posedge clk) disable iff (reset) mem_wr_en |=> !mem_wr_en)
        else $error("back to back sram writes");

endmodule

`default_nettype wire

// ==== queue_mgr/read_issue.sv ====
// read side pacing fsm and sram read port register
`timescale 1ns/100ps
`default_nettype none

module read_issue
#(
    parameter int addr_w = sram_fifo_pkg::ADDR_W
)
(
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              read_req,
    input  wire sram_fifo_pkg::queue_id_t    read_queue_id,
    input  wire sram_fifo_pkg::queue_flags_t read_empty,
    input  wire [addr_w-1:0]                 head_addr,
    output logic                             read_accept,
    output sram_fifo_pkg::queue_id_t         read_accept_id,
    output logic                             read_busy,
    output logic                             mem_rd_en,
    output logic [addr_w-1:0]                mem_rd_addr
);

    import sram_fifo_pkg::*;

    burst_state_t state;
    burst_state_t state_next;

    // requests to an empty queue are ignored
    assign read_busy      = (state == burst_halfway);
    assign read_accept    = read_req && !read_busy && !read_empty[read_queue_id];
    assign read_accept_id = read_queue_id;

    always_comb
    begin
        case (state)
            burst_off:     state_next = read_accept ? burst_halfway : burst_off;
            burst_halfway: state_next = burst_off;
            default:       state_next = burst_off;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= burst_off;
            mem_rd_en <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            mem_rd_en <= read_accept;
        end
    end

    // head address goes out with the enable
    always_ff @(posedge clk)
    begin
        mem_rd_addr <= head_addr;
    end

    assert property (@(posedge clk) disable iff (reset) mem_rd_en |=> !mem_rd_en)
        else $error("back to back sram reads");

endmodule

`default_nettype wire

// ==== verilog/return_fifo.sv ====
// fall-through buffer for sram read data and word unpacking
`timescale 1ns/100ps
`default_nettype none

module return_fifo
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          mem_rd_valid,
    input  wire sram_fifo_pkg::mem_word_t mem_rd_data,
    output logic                         read_valid,
    output sram_fifo_pkg::payload_t      read_data,
    output sram_fifo_pkg::queue_id_t     read_data_queue_id
);

    import sram_fifo_pkg::*;

    localparam int depth = 4;
    localparam int ptr_w = 2;

    mem_word_t        buf_mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             pop;
    mem_word_t        head_word;

    // no back-pressure, drain every cycle
    assign pop       = (count != '0);
    assign head_word = buf_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (mem_rd_valid)
            buf_mem[wr_ptr] <= mem_rd_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (mem_rd_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({mem_rd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // unpack {valid, queue id, payload}
    assign read_valid         = pop && head_word[DATA_W+QUEUE_ID_W];
    assign read_data_queue_id = head_word[DATA_W +: QUEUE_ID_W];
    assign read_data          = head_word[DATA_W-1:0];

    assert property (@(posedge clk) disable iff (reset) mem_rd_valid |-> count != depth)
        else $error("return buffer overflow");

endmodule

`default_nettype wire

// ==== verilog/sram_fifo_top.sv ====
// top level joining the queue table, both issuers and the return buffer
`timescale 1ns/100ps
`default_nettype none

module sram_fifo_top
#(
    parameter int addr_w = sram_fifo_pkg::ADDR_W
)
(
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              write_valid,
    input  wire sram_fifo_pkg::queue_id_t    write_queue_id,
    input  wire sram_fifo_pkg::payload_t     write_data,
    output logic                             write_busy,
    output sram_fifo_pkg::queue_flags_t      write_full,
    input  wire                              read_req,
    input  wire sram_fifo_pkg::queue_id_t    read_queue_id,
    output logic                             read_busy,
    output sram_fifo_pkg::queue_flags_t      read_empty,
    output logic                             read_valid,
    output sram_fifo_pkg::payload_t          read_data,
    output sram_fifo_pkg::queue_id_t         read_data_queue_id,
    output logic                             mem_wr_en,
    output logic [addr_w-1:0]                mem_wr_addr,
    output sram_fifo_pkg::mem_word_t         mem_wr_data,
    output logic                             mem_rd_en,
    output logic [addr_w-1:0]                mem_rd_addr,
    input  wire                              mem_rd_valid,
    input  wire sram_fifo_pkg::mem_word_t    mem_rd_data
);

    import sram_fifo_pkg::*;

    logic              write_accept;
    queue_id_t         write_accept_id;
    logic              read_accept;
    queue_id_t         read_accept_id;
    logic [addr_w-1:0] tail_addr;
    logic [addr_w-1:0] head_addr;

    ////////////////////////////////////////
    // queue manager
    ////////////////////////////////////////

    queue_table #(.addr_w(addr_w)) u_queue_table
    (
        .clk             (clk),
        .reset           (reset),
        .write_accept    (write_accept),
        .write_accept_id (write_accept_id),
        .read_accept     (read_accept),
        .read_accept_id  (read_accept_id),
        .write_queue_id  (write_queue_id),
        .read_queue_id   (read_queue_id),
        .tail_addr       (tail_addr),
        .head_addr       (head_addr),
        .write_full      (write_full),
        .read_empty      (read_empty)
    );

    write_issue #(.addr_w(addr_w)) u_write_issue
    (
        .clk             (clk),
        .reset           (reset),
        .write_valid     (write_valid),
        .write_queue_id  (write_queue_id),
        .write_data      (write_data),
        .write_full      (write_full),
        .tail_addr       (tail_addr),
        .write_accept    (write_accept),
        .write_accept_id (write_accept_id),
        .write_busy      (write_busy),
        .mem_wr_en       (mem_wr_en),
        .mem_wr_addr     (mem_wr_addr),
        .mem_wr_data     (mem_wr_data)
    );

    read_issue #(.addr_w(addr_w)) u_read_issue
    (
        .clk            (clk),
        .reset          (reset),
        .read_req       (read_req),
        .read_queue_id  (read_queue_id),
        .read_empty     (read_empty),
        .head_addr      (head_addr),
        .read_accept    (read_accept),
        .read_accept_id (read_accept_id),
        .read_busy      (read_busy),
        .mem_rd_en      (mem_rd_en),
        .mem_rd_addr    (mem_rd_addr)
    );

    ////////////////////////////////////////
    // return path
    ////////////////////////////////////////

    return_fifo u_return_fifo
    (
        .clk                (clk),
        .reset              (reset),
        .mem_rd_valid       (mem_rd_valid),
        .mem_rd_data        (mem_rd_data),
        .read_valid         (read_valid),
        .read_data          (read_data),
        .read_data_queue_id (read_data_queue_id)
    );

endmodule

`default_nettype wire

// ==== verif/sram_model.sv ====
// behavioural sram with separate write and read ports and a two cycle read latency
`timescale 1ns/100ps
`default_nettype none

module sram_model
#(
    parameter int addr_w = sram_fifo_pkg::ADDR_W
)
(
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           mem_wr_en,
    input  wire [addr_w-1:0]              mem_wr_addr,
    input  wire sram_fifo_pkg::mem_word_t mem_wr_data,
    input  wire                           mem_rd_en,
    input  wire [addr_w-1:0]              mem_rd_addr,
    output logic                          mem_rd_valid,
    output sram_fifo_pkg::mem_word_t      mem_rd_data
);

    import sram_fifo_pkg::*;

    mem_word_t mem [1 << addr_w];
    mem_word_t stage_data;
    logic      stage_valid;

    // array read sees the contents from before this edge's write
    always_ff @(posedge clk)
    begin
        if (mem_wr_en)
            mem[mem_wr_addr] <= mem_wr_data;
        stage_data  <= mem[mem_rd_addr];
        mem_rd_data <= stage_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage_valid  <= 1'b0;
            mem_rd_valid <= 1'b0;
        end
        else
        begin
            stage_valid  <= mem_rd_en;
            mem_rd_valid <= stage_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_sram_fifo.sv ====
// testbench for the sram queues: stimulus, scoreboard, assertions and timeout
`timescale 1ns/100ps
`default_nettype none

module tb_sram_fifo;

    import sram_fifo_pkg::*;

    localparam int addr_w  = 8;
    localparam int off_w   = addr_w - QUEUE_ID_W;
    localparam int depth   = 1 << off_w;
    localparam int full_at = depth - FULL_MARGIN;
    // tests need about 700 cycles
    localparam int max_cycles = 2000;

    logic              clk = 1'b0;
    logic              reset;
    logic              write_valid;
    queue_id_t         write_queue_id;
    payload_t          write_data;
    logic              write_busy;
    queue_flags_t      write_full;
    logic              read_req;
    queue_id_t         read_queue_id;
    logic              read_busy;
    queue_flags_t      read_empty;
    logic              read_valid;
    payload_t          read_data;
    queue_id_t         read_data_queue_id;
    logic              mem_wr_en;
    logic [addr_w-1:0] mem_wr_addr;
    mem_word_t         mem_wr_data;
    logic              mem_rd_en;
    logic [addr_w-1:0] mem_rd_addr;
    logic              mem_rd_valid;
    mem_word_t         mem_rd_data;

    integer            seed = 94839;
    int                cycle_count = 0;

    // reference model of the queues
    payload_t          exp_q [NUM_QUEUES][$];
    int                occ_model [NUM_QUEUES];
    int                returned [NUM_QUEUES];
    int                wr_total [NUM_QUEUES];
    int                rd_total [NUM_QUEUES];
    queue_flags_t      exp_full;
    queue_flags_t      exp_empty;
    logic              wr_busy_model;
    logic              rd_busy_model;
    logic [3:0]        rd_pipe;
    queue_id_t         rd_id_pipe [4];
    logic              wr_seen;
    logic              rd_seen;
    logic              exp_known;
    payload_t          exp_front;
    mem_word_t         exp_wr_word;
    logic [addr_w-1:0] exp_wr_addr;
    logic [addr_w-1:0] exp_rd_addr;

    always #50 clk = ~clk;

    sram_fifo_top #(.addr_w(addr_w)) uut
    (
        .clk(clk), .reset(reset),
        .write_valid(write_valid), .write_queue_id(write_queue_id), .write_data(write_data),
        .write_busy(write_busy), .write_full(write_full),
        .read_req(read_req), .read_queue_id(read_queue_id), .read_busy(read_busy),
        .read_empty(read_empty), .read_valid(read_valid), .read_data(read_data),
        .read_data_queue_id(read_data_queue_id),
        .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr),
        .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data)
    );

    sram_model #(.addr_w(addr_w)) u_sram
    (
        .clk(clk), .reset(reset),
        .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr),
        .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data)
    );

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////

    always_comb
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            exp_full[q]  = (occ_model[q] >= full_at);
            exp_empty[q] = (occ_model[q] == 0);
        end
    end

    assign wr_seen = write_valid && !wr_busy_model && !exp_full[write_queue_id];
    assign rd_seen = read_req && !rd_busy_model && !exp_empty[read_queue_id];

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int q = 0; q < NUM_QUEUES; q++)
                occ_model[q] <= 0;
            wr_busy_model <= 1'b0;
            rd_busy_model <= 1'b0;
            rd_pipe       <= '0;
        end
        else
        begin
            wr_busy_model <= wr_seen;
            rd_busy_model <= rd_seen;
            rd_pipe       <= {rd_pipe[2:0], rd_seen};
            rd_id_pipe[0] <= read_queue_id;
            for (int i = 1; i < 4; i++)
                rd_id_pipe[i] <= rd_id_pipe[i-1];
            for (int q = 0; q < NUM_QUEUES; q++)
                occ_model[q] <= occ_model[q] + int'(wr_seen && write_queue_id == queue_id_t'(q))
                                - int'(rd_seen && read_queue_id == queue_id_t'(q));
            // tail and head offsets count accepted accesses, wrapping in the region
            if (wr_seen)
            begin
                exp_wr_word <= {1'b1, write_queue_id, write_data};
                exp_wr_addr <= {write_queue_id, off_w'(wr_total[write_queue_id])};
                wr_total[write_queue_id] <= wr_total[write_queue_id] + 1;
                exp_q[write_queue_id].push_back(write_data);
            end
            if (rd_seen)
            begin
                exp_rd_addr <= {read_queue_id, off_w'(rd_total[read_queue_id])};
                rd_total[read_queue_id] <= rd_total[read_queue_id] + 1;
            end
            if (read_valid && exp_q[read_data_queue_id].size() != 0)
            begin
                void'(exp_q[read_data_queue_id].pop_front());
                returned[read_data_queue_id]++;
            end
        end
    end

    // expected head word, settled before the next rising edge
    always @(negedge clk)
    begin
        exp_known = (exp_q[read_data_queue_id].size() != 0);
        if (exp_known)
            exp_front = exp_q[read_data_queue_id][0];
        else
            exp_front = '0;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_reset_state: assert property (@(posedge clk) $fell(reset) |-> read_empty == '1 &&
            write_full == '0 && !mem_wr_en && !mem_rd_en && !read_valid)
        else stop_with_failure($sformatf("error at time %0t: outputs not idle after reset", $time));
    a_flags: assert property (@(posedge clk) disable iff (reset)
            write_full == exp_full && read_empty == exp_empty)
        else stop_with_failure($sformatf("error at time %0t: empty or full flags wrong", $time));
    a_busy: assert property (@(posedge clk) disable iff (reset)
            write_busy == wr_busy_model && read_busy == rd_busy_model)
        else stop_with_failure($sformatf("error at time %0t: busy flags wrong", $time));
    a_mem_access: assert property (@(posedge clk) disable iff (reset)
            mem_wr_en == wr_busy_model && mem_rd_en == rd_pipe[0])
        else stop_with_failure($sformatf("error at time %0t: unexpected sram access", $time));
    a_wr_spacing: assert property (@(posedge clk) disable iff (reset) mem_wr_en |=> !mem_wr_en)
        else stop_with_failure($sformatf("error at time %0t: sram writes back to back", $time));
    a_rd_spacing: assert property (@(posedge clk) disable iff (reset) mem_rd_en |=> !mem_rd_en)
        else stop_with_failure($sformatf("error at time %0t: sram reads back to back", $time));
    a_wr_word: assert property (@(posedge clk) disable iff (reset) mem_wr_en |->
            mem_wr_data == exp_wr_word && mem_wr_addr == exp_wr_addr)
        else stop_with_failure($sformatf("error at time %0t: bad sram write word", $time));
    a_rd_addr: assert property (@(posedge clk) disable iff (reset) mem_rd_en |->
            mem_rd_addr == exp_rd_addr)
        else stop_with_failure($sformatf("error at time %0t: wrong sram read address", $time));
    a_latency: assert property (@(posedge clk) disable iff (reset) read_valid == rd_pipe[3])
        else stop_with_failure($sformatf("error at time %0t: read_valid latency wrong", $time));
    a_ret_id: assert property (@(posedge clk) disable iff (reset)
            read_valid |-> read_data_queue_id == rd_id_pipe[3])
        else stop_with_failure($sformatf("error at time %0t: wrong returned queue id", $time));
    a_ret_data: assert property (@(posedge clk) disable iff (reset)
            read_valid |-> exp_known && read_data == exp_front)
        else stop_with_failure($sformatf("error at time %0t: returned word out of order", $time));

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
            stop_with_failure($sformatf("timeout, run still going after %0d cycles", max_cycles));
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // hold above 1 keeps the strobe up through the busy cycle
    task automatic offer_write(input queue_id_t q, input int hold);
        write_valid    = 1'b1;
        write_queue_id = q;
        write_data     = payload_t'({$random(seed), $random(seed)});
        repeat (hold) @(negedge clk);
        write_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic offer_read(input queue_id_t q, input int hold);
        read_req      = 1'b1;
        read_queue_id = q;
        repeat (hold) @(negedge clk);
        read_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic drain_queue(input queue_id_t q);
        while (occ_model[q] != 0)
            offer_read(q, 1);
        while (rd_pipe != '0)
            @(negedge clk);
    endtask

    task automatic random_traffic(input int cycles);
        repeat (cycles)
        begin
            write_valid    = 1'($random(seed));
            write_queue_id = queue_id_t'($random(seed));
            write_data     = payload_t'({$random(seed), $random(seed)});
            read_req       = 1'($random(seed));
            read_queue_id  = queue_id_t'($random(seed));
            @(negedge clk);
        end
        write_valid = 1'b0;
        read_req    = 1'b0;
        @(negedge clk);
    endtask

    initial
    begin
        int start_count;
        int leftover;
        reset          = 1'b1;
        write_valid    = 1'b0;
        write_queue_id = '0;
        write_data     = '0;
        read_req       = 1'b0;
        read_queue_id  = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // one queue, in order
        for (int i = 0; i < 8; i++)
            offer_write(2'd1, 1);
        drain_queue(2'd1);

        // random mix over all queues
        random_traffic(300);
        for (int q = 0; q < NUM_QUEUES; q++)
            drain_queue(queue_id_t'(q));

        // fill queue 2 past its full level
        for (int i = 0; i < 70; i++)
            offer_write(2'd2, 1);
        assert (occ_model[2] == full_at && write_full[2])
            else stop_with_failure($sformatf("error at time %0t: queue 2 not full after 70 writes",
                                             $time));
        start_count = returned[2];
        drain_queue(2'd2);
        assert (returned[2] - start_count == full_at)
            else stop_with_failure($sformatf("error at time %0t: queue 2 returned %0d words",
                                             $time, returned[2] - start_count));

        // strobes held through the busy cycle, queue 0 keeps a word for the second read
        offer_write(2'd0, 2);
        offer_write(2'd0, 2);
        offer_read(2'd0, 2);
        drain_queue(2'd0);

        // reads of an empty queue
        offer_read(2'd3, 1);
        offer_read(2'd3, 3);
        repeat (6) @(negedge clk);

        leftover = 0;
        for (int q = 0; q < NUM_QUEUES; q++)
            leftover += exp_q[q].size();
        if (leftover != 0)
            stop_with_failure($sformatf("%0d written words never came back", leftover));
        else
        begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/sram_fifo_pkg.sv
queue_mgr/queue_table.sv
queue_mgr/write_issue.sv
queue_mgr/read_issue.sv
verilog/return_fifo.sv
verilog/sram_fifo_top.sv
verif/sram_model.sv
verif/tb_sram_fifo.sv

// ==== Makefile ====
# Verilator build of the sram queue testbench

SRCS := $(shell cat vlog.f)

obj_dir/Vtb_sram_fifo: vlog.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module tb_sram_fifo -f vlog.f

run: obj_dir/Vtb_sram_fifo
	./obj_dir/Vtb_sram_fifo

clean:
	rm -rf obj_dir

.PHONY: run clean
